//--- Bender.yml
# Camera capture front end and host FIFO loopback bridge

package:
  name: camera_fifo

# camera_defs.svh sits in the project root
export_include_dirs:
  - .

sources:
  # Design, in compile order
  - files:
      - camera_pkg.sv
      - ccd_capture.sv
      - frame_count_display.sv
      - fifo_loopback.sv
      - camera_fifo_top.sv
  # Testbench
  - target: test
    files:
      - tb_camera_fifo_top.sv

//--- camera_defs.svh
/*
 * Camera capture and host FIFO bridge
 * Width and count macros shared by every block
 */

`ifndef CAMERA_DEFS_SVH
`define CAMERA_DEFS_SVH

// ==============================
// Sensor side
// ==============================
`define PIXEL_W     12
`define COORD_W     16
`define FRAME_W     24

// ==============================
// Host FIFO and board outputs
// ==============================
`define FIFO_W      32
`define SEG_W       7
`define HEX_DIGITS  6
`define LED_W       10

`endif

//--- camera_fifo_top.sv
/*
 * Camera capture and host FIFO bridge top level
 * Joins sensor capture, frame count display and FIFO loopback
 */

`include "camera_defs.svh"

module camera_fifo_top
	import camera_pkg::*;
(
	input  logic             CLOCK_50,
	input  logic             rst,
	// Sensor
	input  pixel_t           d5m_d,
	input  logic             d5m_fval,
	input  logic             d5m_lval,
	input  logic             start_capture,
	input  logic             stop_capture,
	// Host FIFO status and data
	input  fifo_word_t       h2f_readdata,
	input  logic             h2f_empty,
	input  logic             f2h_full,
	// Captured pixel stream
	output pixel_t           pixel_data,
	output logic             pixel_valid,
	output coord_t           col_count,
	// Board display
	output logic [`LED_W-1:0] leds,
	output seg_t             hex0,
	output seg_t             hex1,
	output seg_t             hex2,
	output seg_t             hex3,
	output seg_t             hex4,
	output seg_t             hex5,
	// Host FIFO strobes
	output logic             h2f_read,
	output fifo_word_t       f2h_writedata,
	output logic             f2h_write
);

	coord_t       line_count;
	frame_count_t frame_count;

	// ==============================
	// Sensor capture
	// ==============================
	ccd_capture u_capture (
		.CLOCK_50      (CLOCK_50),
		.rst           (rst),
		.d5m_d         (d5m_d),
		.d5m_fval      (d5m_fval),
		.d5m_lval      (d5m_lval),
		.start_capture (start_capture),
		.stop_capture  (stop_capture),
		.pixel_data    (pixel_data),
		.pixel_valid   (pixel_valid),
		.col_count     (col_count),
		.line_count    (line_count),
		.frame_count   (frame_count)
	);

	// Line count on the LEDs
	assign leds = line_count[`LED_W-1:0];

	// Frame count on the hex digits
	frame_count_display u_display (
		.frame_count (frame_count),
		.hex0        (hex0),
		.hex1        (hex1),
		.hex2        (hex2),
		.hex3        (hex3),
		.hex4        (hex4),
		.hex5        (hex5)
	);

	// ==============================
	// Host FIFO loopback
	// ==============================
	fifo_loopback u_loopback (
		.CLOCK_50      (CLOCK_50),
		.rst           (rst),
		.h2f_readdata  (h2f_readdata),
		.h2f_empty     (h2f_empty),
		.f2h_full      (f2h_full),
		.h2f_read      (h2f_read),
		.f2h_writedata (f2h_writedata),
		.f2h_write     (f2h_write)
	);

endmodule

//--- camera_pkg.sv
/*
 * Camera capture shared types
 * Pixel, counter and FIFO word types plus the FSM state encodings
 */

`include "camera_defs.svh"

package camera_pkg;

	// Data types
	typedef logic [`PIXEL_W-1:0] pixel_t;
	typedef logic [`COORD_W-1:0] coord_t;
	typedef logic [`FRAME_W-1:0] frame_count_t;
	typedef logic [`FIFO_W-1:0]  fifo_word_t;
	// Active low, bit 6 is segment g, bit 0 is segment a
	typedef logic [`SEG_W-1:0]   seg_t;

	// Capture control FSM
	typedef enum logic [1:0] {
		cap_stopped,
		cap_waiting,
		cap_in_frame
	} capture_state_t;

	// Host to FPGA reader FSM
	typedef enum logic [1:0] {
		rd_idle,
		rd_wait,
		rd_capture
	} reader_state_t;

	// FPGA to host writer FSM
	typedef enum logic {
		wr_idle,
		wr_finish
	} writer_state_t;

endpackage

//--- ccd_capture.sv
/*
 * Camera sensor capture front end
 * Registers pixel and valid inputs, runs start/stop control and keeps
 * column, line and frame counters; valid pixels leave two cycles later
 */

module ccd_capture
	import camera_pkg::*;
(
	input  logic         CLOCK_50,
	input  logic         rst,
	input  pixel_t       d5m_d,
	input  logic         d5m_fval,
	input  logic         d5m_lval,
	input  logic         start_capture,
	input  logic         stop_capture,
	output pixel_t       pixel_data,
	output logic         pixel_valid,
	output coord_t       col_count,
	output coord_t       line_count,
	output frame_count_t frame_count
);

	// Input register stage
	pixel_t d_reg;
	logic   fval_reg;
	logic   lval_reg;
	// One more stage of the valids for edge detect
	logic   fval_prev;
	logic   lval_prev;

	capture_state_t state;
	// Stop request seen mid frame, acted on at frame end
	logic   stop_seen;
	// Running column index of the current line
	coord_t col_cnt;

	logic   frame_rise;
	logic   frame_fall;
	logic   line_fall;
	logic   frame_start;
	logic   capturing;

	// ==============================
	// Sensor input sampling
	// ==============================
	always_ff @(posedge CLOCK_50) begin
		d_reg <= d5m_d;
		if (rst) begin
			fval_reg  <= 1'b0;
			lval_reg  <= 1'b0;
			fval_prev <= 1'b0;
			lval_prev <= 1'b0;
		end else begin
			fval_reg  <= d5m_fval;
			lval_reg  <= d5m_lval;
			fval_prev <= fval_reg;
			lval_prev <= lval_reg;
		end
	end

	assign frame_rise = fval_reg & ~fval_prev;
	assign frame_fall = ~fval_reg & fval_prev;
	assign line_fall  = ~lval_reg & lval_prev;

	// A frame is taken only when armed and no stop is pending
	assign frame_start = (state == cap_waiting) & frame_rise & ~stop_capture;
	// First frame cycle counts as captured too
	assign capturing = (state == cap_in_frame) | frame_start;

	// ==============================
	// Start/stop control
	// ==============================
	always_ff @(posedge CLOCK_50) begin
		if (rst) begin
			state     <= cap_stopped;
			stop_seen <= 1'b0;
		end else begin
			case (state)
				cap_stopped: begin
					if (start_capture)
						state <= cap_waiting;
				end
				cap_waiting: begin
					// Between frames a stop is immediate
					if (stop_capture)
						state <= cap_stopped;
					else if (frame_rise)
						state <= cap_in_frame;
				end
				cap_in_frame: begin
					if (frame_fall) begin
						state     <= (stop_seen | stop_capture) ? cap_stopped : cap_waiting;
						stop_seen <= 1'b0;
					end else if (stop_capture) begin
						stop_seen <= 1'b1;
					end
				end
				default: state <= cap_stopped;
			endcase
		end
	end

	// Column, line and frame counters
	always_ff @(posedge CLOCK_50) begin
		if (rst) begin
			col_cnt     <= '0;
			line_count  <= '0;
			frame_count <= '0;
		end else begin
			if (lval_reg)
				col_cnt <= col_cnt + 1'b1;
			else
				col_cnt <= '0;
			if (frame_start) begin
				frame_count <= frame_count + 1'b1;
				line_count  <= '0;
			end else if ((state == cap_in_frame) && line_fall) begin
				line_count <= line_count + 1'b1;
			end
		end
	end

	// Output register, column index travels with its pixel
	always_ff @(posedge CLOCK_50) begin
		pixel_data <= d_reg;
		if (rst) begin
			pixel_valid <= 1'b0;
			col_count   <= '0;
		end else begin
			pixel_valid <= capturing & fval_reg & lval_reg;
			col_count   <= col_cnt;
		end
	end

endmodule

//--- fifo_loopback.sv
/*
 * Host FIFO loopback bridge
 * Pops words from the host-to-FPGA FIFO into a one-word buffer and
 * pushes them to the FPGA-to-host FIFO, one word in flight at a time
 */

module fifo_loopback
	import camera_pkg::*;
(
	input  logic       CLOCK_50,
	input  logic       rst,
	input  fifo_word_t h2f_readdata,
	input  logic       h2f_empty,
	input  logic       f2h_full,
	output logic       h2f_read,
	output fifo_word_t f2h_writedata,
	output logic       f2h_write
);

	reader_state_t rd_state;
	writer_state_t wr_state;

	// One-word buffer between the two FIFOs
	fifo_word_t data_buf;
	logic       buf_valid;
	logic       buf_load;
	logic       buf_free;

	// Read strobe only with data waiting and room in the buffer
	assign h2f_read = (rd_state == rd_idle) & ~h2f_empty & ~buf_valid;
	assign buf_load = (rd_state == rd_capture);
	assign buf_free = (wr_state == wr_finish);

	// ==============================
	// Reader FSM
	// ==============================
	always_ff @(posedge CLOCK_50) begin
		if (rst) begin
			rd_state <= rd_idle;
		end else begin
			case (rd_state)
				rd_idle: begin
					if (h2f_read)
						rd_state <= rd_wait;
				end
				// FIFO presents the popped word here
				rd_wait:    rd_state <= rd_capture;
				rd_capture: rd_state <= rd_idle;
				default:    rd_state <= rd_idle;
			endcase
		end
	end

	// Word latch
	always_ff @(posedge CLOCK_50) begin
		if (buf_load)
			data_buf <= h2f_readdata;
	end

	// Set by the reader, cleared by the writer
	always_ff @(posedge CLOCK_50) begin
		if (rst)
			buf_valid <= 1'b0;
		else if (buf_load)
			buf_valid <= 1'b1;
		else if (buf_free)
			buf_valid <= 1'b0;
	end

	// ==============================
	// Writer FSM
	// ==============================
	always_ff @(posedge CLOCK_50) begin
		if (rst) begin
			wr_state  <= wr_idle;
			f2h_write <= 1'b0;
		end else begin
			case (wr_state)
				wr_idle: begin
					// Space downstream and a word to send
					if (buf_valid && !f2h_full) begin
						f2h_write <= 1'b1;
						wr_state  <= wr_finish;
					end
				end
				wr_finish: begin
					f2h_write <= 1'b0;
					wr_state  <= wr_idle;
				end
				default: begin
					f2h_write <= 1'b0;
					wr_state  <= wr_idle;
				end
			endcase
		end
	end

	// Write data follows the buffer, valid under the strobe
	always_ff @(posedge CLOCK_50) begin
		if ((wr_state == wr_idle) && buf_valid && !f2h_full)
			f2h_writedata <= data_buf;
	end

endmodule

//--- frame_count_display.sv
/*
 * Frame count display
 * Six hex digits on active-low seven-segment outputs, no state
 */

`include "camera_defs.svh"

module frame_count_display
	import camera_pkg::*;
(
	input  frame_count_t frame_count,
	output seg_t         hex0,
	output seg_t         hex1,
	output seg_t         hex2,
	output seg_t         hex3,
	output seg_t         hex4,
	output seg_t         hex5
);

	// Segment table, g down to a, lit on 0
	localparam seg_t SEG_TABLE [16] = '{
		7'b1000000, 7'b1111001, 7'b0100100, 7'b0110000,
		7'b0011001, 7'b0010010, 7'b0000010, 7'b1111000,
		7'b0000000, 7'b0010000, 7'b0001000, 7'b0000011,
		7'b1000110, 7'b0100001, 7'b0000110, 7'b0001110
	};

	seg_t digit [`HEX_DIGITS];

	// One nibble per digit, lowest nibble on digit 0
	always_comb begin
		for (int i = 0; i < `HEX_DIGITS; i++) begin
			digit[i] = SEG_TABLE[frame_count[4*i +: 4]];
		end
	end

	assign hex0 = digit[0];
	assign hex1 = digit[1];
	assign hex2 = digit[2];
	assign hex3 = digit[3];
	assign hex4 = digit[4];
	assign hex5 = digit[5];

endmodule

//--- list.f
+incdir+.
camera_pkg.sv
ccd_capture.sv
frame_count_display.sv
fifo_loopback.sv
camera_fifo_top.sv
tb_camera_fifo_top.sv

//--- tb_camera_fifo_top.sv
/*
 * Testbench for the camera capture and host FIFO bridge
 * Random sensor frames and host FIFO traffic checked against reference models
 */

`include "camera_defs.svh"

module tb_camera_fifo_top
	import camera_pkg::*;
();

	localparam int frame_target = 20;
	localparam int word_target  = 200;
	// About 20 frames and 200 words plus margin
	localparam int cycle_limit  = 6000;

	logic              CLOCK_50;
	logic              rst;
	pixel_t            d5m_d;
	logic              d5m_fval;
	logic              d5m_lval;
	logic              start_capture;
	logic              stop_capture;
	fifo_word_t        h2f_readdata;
	logic              h2f_empty;
	logic              f2h_full;
	pixel_t            pixel_data;
	logic              pixel_valid;
	coord_t            col_count;
	logic [`LED_W-1:0] leds;
	seg_t              hex0;
	seg_t              hex1;
	seg_t              hex2;
	seg_t              hex3;
	seg_t              hex4;
	seg_t              hex5;
	logic              h2f_read;
	fifo_word_t        f2h_writedata;
	logic              f2h_write;

	integer seed;
	int     errors;
	int     cycles;
	logic   timed_out;

	// Capture reference model of the registered sensor view
	capture_state_t m_state;
	logic           m_stop;
	logic           m_fval_r;
	logic           m_fval_p;
	logic           m_lval_r;
	logic           m_lval_p;
	pixel_t         m_d_r;
	coord_t         m_idx_r;
	coord_t         m_line;
	frame_count_t   m_frame;

	// Sensor generator
	int     sens_state;
	int     sens_cnt;
	int     lines_left;
	int     pix_left;
	int     line_pos;
	int     frames_gen;
	coord_t pix_idx;

	// Host FIFO models
	fifo_word_t h2f_q [$];
	fifo_word_t f2h_q [$];
	fifo_word_t exp_q [$];
	int         f2h_cap;
	int         words_in;
	int         words_out;
	logic       read_pending;
	logic       write_prev;

	camera_fifo_top uut (.*);

	always #5 CLOCK_50 = ~CLOCK_50;

	function automatic int rand_below(input int n);
		return $unsigned($random(seed)) % n;
	endfunction

	// Standard hex patterns with g as the top bit and a segment lit on 0
	function automatic seg_t seg_of(input logic [3:0] n);
		case (n)
			4'h0: return 7'b1000000;
			4'h1: return 7'b1111001;
			4'h2: return 7'b0100100;
			4'h3: return 7'b0110000;
			4'h4: return 7'b0011001;
			4'h5: return 7'b0010010;
			4'h6: return 7'b0000010;
			4'h7: return 7'b1111000;
			4'h8: return 7'b0000000;
			4'h9: return 7'b0010000;
			4'ha: return 7'b0001000;
			4'hb: return 7'b0000011;
			4'hc: return 7'b1000110;
			4'hd: return 7'b0100001;
			4'he: return 7'b0000110;
			default: return 7'b0001110;
		endcase
	endfunction

	task report_error(input string msg);
		$display("error at %0t: %s", $time, msg);
		errors++;
	endtask

	task check_hex(input frame_count_t n);
		seg_t got [`HEX_DIGITS];
		got = '{hex0, hex1, hex2, hex3, hex4, hex5};
		for (int i = 0; i < `HEX_DIGITS; i++) begin
			if (got[i] !== seg_of(n[4*i +: 4]))
				report_error($sformatf("hex%0d is %b, count %h", i, got[i], n));
		end
	endtask

	// ==============================
	// Capture model and checks
	// ==============================
	task capture_check;
		logic rise;
		logic fall;
		logic line_end;
		logic new_frame;
		logic exp_valid;
		rise      = m_fval_r & ~m_fval_p;
		fall      = ~m_fval_r & m_fval_p;
		line_end  = ~m_lval_r & m_lval_p;
		// A stop seen while waiting wins over a new frame
		new_frame = (m_state == cap_waiting) && rise && !stop_capture;
		exp_valid = ((m_state == cap_in_frame) || new_frame) && m_fval_r && m_lval_r;
		if (new_frame) begin
			m_frame = m_frame + 1'b1;
			m_line  = '0;
		end else if ((m_state == cap_in_frame) && line_end) begin
			m_line = m_line + 1'b1;
		end
		case (m_state)
			cap_stopped: begin
				if (start_capture)
					m_state = cap_waiting;
			end
			cap_waiting: begin
				if (stop_capture)
					m_state = cap_stopped;
				else if (rise)
					m_state = cap_in_frame;
			end
			default: begin
				// Stop only lands at the frame end
				if (fall) begin
					m_state = (m_stop || stop_capture) ? cap_stopped : cap_waiting;
					m_stop  = 1'b0;
				end else if (stop_capture) begin
					m_stop = 1'b1;
				end
			end
		endcase
		if (pixel_valid !== exp_valid)
			report_error($sformatf("pixel_valid %b, expected %b", pixel_valid, exp_valid));
		if (exp_valid && (pixel_data !== m_d_r))
			report_error($sformatf("pixel_data %h, expected %h", pixel_data, m_d_r));
		if (exp_valid && (col_count !== m_idx_r))
			report_error($sformatf("col_count %0d, expected %0d", col_count, m_idx_r));
		if (exp_valid && (leds !== m_line[`LED_W-1:0]))
			report_error($sformatf("leds %0d, expected %0d", leds, m_line[`LED_W-1:0]));
		check_hex(m_frame);
		m_fval_p = m_fval_r;
		m_lval_p = m_lval_r;
		m_fval_r = d5m_fval;
		m_lval_r = d5m_lval;
		m_d_r    = d5m_d;
		m_idx_r  = pix_idx;
	endtask

	// ==============================
	// Host FIFO models
	// ==============================
	task fifo_step;
		fifo_word_t want;
		fifo_word_t word;
		// Popped word shows up the cycle after the read
		if (read_pending) begin
			if (h2f_q.size() == 0)
				report_error("read taken from an empty inbound FIFO");
			else
				h2f_readdata = h2f_q.pop_front();
		end
		if (f2h_write) begin
			if (f2h_full)
				report_error("f2h_write pulsed while f2h_full was high");
			if (write_prev)
				report_error("f2h_write lasted more than one cycle");
			if (exp_q.size() == 0) begin
				report_error("word written with no word outstanding");
			end else begin
				want = exp_q.pop_front();
				if (f2h_writedata !== want)
					report_error($sformatf("f2h_writedata %h, expected %h", f2h_writedata, want));
			end
			f2h_q.push_back(f2h_writedata);
			words_out++;
		end
		write_prev = f2h_write;
		// Host drains the outbound side at random
		if ((f2h_q.size() > 0) && (rand_below(3) == 0))
			void'(f2h_q.pop_front());
		if ((words_in < word_target) && (rand_below(4) == 0)) begin
			word = $random(seed);
			h2f_q.push_back(word);
			exp_q.push_back(word);
			words_in++;
		end
		h2f_empty = (h2f_q.size() == 0);
		f2h_full  = (f2h_q.size() >= f2h_cap);
	endtask

	// Read strobe is combinational so it is sampled mid low phase
	task read_sample;
		if (h2f_read && h2f_empty)
			report_error("h2f_read pulsed while h2f_empty was high");
		if (h2f_read && read_pending)
			report_error("h2f_read lasted more than one cycle");
		read_pending = h2f_read;
	endtask

	// Sensor state 0 is the frame gap, 1 a line and 2 a line gap inside the frame
	task sensor_step;
		case (sens_state)
			0: begin
				// Start and stop move between frames
				if (rand_below(8) == 0) begin
					start_capture = (rand_below(4) != 0);
					stop_capture  = (rand_below(4) == 0);
				end
				if (sens_cnt > 0) begin
					sens_cnt--;
				end else if (frames_gen < frame_target) begin
					lines_left = 2 + rand_below(3);
					frames_gen++;
					// Some frames open with a pixel on the first valid cycle
					if (rand_below(3) == 0) begin
						sens_state = 1;
						pix_left   = 4 + rand_below(9);
						line_pos   = 0;
					end else begin
						sens_state = 2;
						sens_cnt   = rand_below(3);
					end
				end
			end
			1: begin
				if (pix_left == 0) begin
					lines_left--;
					sens_state = 2;
					sens_cnt   = (lines_left == 0) ? rand_below(3) : 1 + rand_below(4);
				end
			end
			default: begin
				// Occasional stop inside a frame
				if (rand_below(40) == 0)
					stop_capture = 1'b1;
				if (sens_cnt > 0) begin
					sens_cnt--;
				end else if (lines_left > 0) begin
					sens_state = 1;
					pix_left   = 4 + rand_below(9);
					line_pos   = 0;
				end else begin
					sens_state = 0;
					sens_cnt   = 4 + rand_below(6);
				end
			end
		endcase
		d5m_fval = (sens_state != 0);
		d5m_lval = (sens_state == 1);
		if (sens_state == 1) begin
			d5m_d   = pixel_t'($random(seed));
			pix_idx = coord_t'(line_pos);
			line_pos++;
			pix_left--;
		end
	endtask

	function automatic logic run_done();
		return (frames_gen == frame_target) && (sens_state == 0) && (sens_cnt == 0) &&
			(words_out == word_target);
	endfunction

	initial begin
		seed          = 59718;
		errors        = 0;
		cycles        = 0;
		timed_out     = 1'b0;
		CLOCK_50      = 1'b0;
		rst           = 1'b1;
		d5m_d         = '0;
		d5m_fval      = 1'b0;
		d5m_lval      = 1'b0;
		start_capture = 1'b0;
		stop_capture  = 1'b0;
		h2f_readdata  = '0;
		h2f_empty     = 1'b1;
		f2h_full      = 1'b0;
		m_state       = cap_stopped;
		m_stop        = 1'b0;
		m_fval_r      = 1'b0;
		m_fval_p      = 1'b0;
		m_lval_r      = 1'b0;
		m_lval_p      = 1'b0;
		m_d_r         = '0;
		m_idx_r       = '0;
		m_line        = '0;
		m_frame       = '0;
		sens_state    = 0;
		sens_cnt      = 3;
		lines_left    = 0;
		pix_left      = 0;
		line_pos      = 0;
		frames_gen    = 0;
		pix_idx       = '0;
		words_in      = 0;
		words_out     = 0;
		read_pending  = 1'b0;
		write_prev    = 1'b0;
		f2h_cap       = 1 + rand_below(3);

		repeat (4) @(negedge CLOCK_50);
		if ((pixel_valid !== 1'b0) || (h2f_read !== 1'b0) || (f2h_write !== 1'b0))
			report_error("strobes not low after reset");
		check_hex('0);
		rst = 1'b0;

		// ==============================
		// Main loop with one pass per cycle
		// ==============================
		while (!run_done() && !timed_out) begin
			@(negedge CLOCK_50);
			cycles++;
			capture_check;
			fifo_step;
			sensor_step;
			#1;
			read_sample;
			if (cycles >= cycle_limit)
				timed_out = 1'b1;
		end

		if (timed_out)
			$display("timeout: run did not finish within %0d cycles", cycle_limit);
		else if (m_frame == 0)
			report_error("no frame was captured during the run");
		$display("errors: %0d  frames captured: %0d  words looped: %0d of %0d  cycles: %0d",
			errors, m_frame, words_out, word_target, cycles);
		if ((errors == 0) && !timed_out) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule
